// File: verilog/isa_pkg.sv
package isa_pkg;

	localparam int word_w = 16;
	localparam int reg_w = 3;
	localparam int num_regs = 8;
	localparam int opc_w = 5;
	localparam int imm_w = 8;
	localparam int shamt_w = 3;

	// sub-function fields inside the grouped major opcodes.
	localparam logic [1:0] funct_sll = 2'b00;
	localparam logic [1:0] funct_addu = 2'b01;
	localparam logic [4:0] funct_move = 5'b00000;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_w-1:0] reg_idx_t;

	// major opcode, instr[15:11].
	typedef enum logic [opc_w-1:0] {
		opc_nop   = 5'b00001,
		opc_bnez  = 5'b00101,
		opc_sll   = 5'b00110,
		opc_addiu = 5'b01001,
		opc_li    = 5'b01101,
		opc_move  = 5'b01111,
		opc_addu  = 5'b11100
	} opcode_e;

	typedef enum logic [2:0] {
		op_nop,
		op_li,
		op_addiu,
		op_addu,
		op_sll,
		op_move,
		op_bnez
	} op_e;

	// true for the operations that write a register.
	function automatic logic op_writes(op_e op);
		return op inside {op_li, op_addiu, op_addu, op_sll, op_move};
	endfunction

endpackage

// File: verilog/pipe_pkg.sv
package pipe_pkg;

	import isa_pkg::*;

	// decode to execute.
	typedef struct packed {
		logic     valid;
		op_e      op;
		reg_idx_t dst;
		word_t    opa;
		word_t    opb;
		word_t    imm;   // already extended.
		word_t    pc;
	} dec_ex_t;

	// execute to writeback.
	typedef struct packed {
		logic     valid;
		op_e      op;
		reg_idx_t dst;
		word_t    result;
		logic     branch_taken;
		word_t    target;
	} ex_wb_t;

	// register write, doubles as the unlock.
	typedef struct packed {
		logic     en;
		reg_idx_t addr;
		word_t    data;
	} wb_t;

endpackage

// File: verilog/fetch_decode.sv
`timescale 1ns/1ns

module fetch_decode #(
	parameter isa_pkg::word_t reset_pc = 16'h0000
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  isa_pkg::word_t                instr,
	output isa_pkg::word_t                fetch_pc,
	output isa_pkg::reg_idx_t             rd_addr_a,
	output isa_pkg::reg_idx_t             rd_addr_b,
	input  isa_pkg::word_t                rd_data_a,
	input  isa_pkg::word_t                rd_data_b,
	input  logic [isa_pkg::num_regs-1:0]  locked,
	output logic                          lock_en,
	output isa_pkg::reg_idx_t             lock_addr,
	output logic [isa_pkg::num_regs-1:0]  cancel_lock,
	input  logic [isa_pkg::reg_w:0]       ex_busy_dst,
	input  logic                          redirect_en,
	input  isa_pkg::word_t                redirect_pc,
	output pipe_pkg::dec_ex_t             dec
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t pc_q;
	word_t pc_next;
	opcode_e opc;
	op_e op;
	reg_idx_t rx;
	reg_idx_t ry;
	reg_idx_t rz;
	reg_idx_t dst;
	logic [shamt_w-1:0] shamt;
	word_t imm;
	logic use_a;
	logic use_b;
	logic writes;
	logic ex_busy;
	reg_idx_t ex_dst;
	logic hazard;
	logic issue;

	assign opc = opcode_e'(instr[word_w-1 -: opc_w]);
	assign rx = instr[10:8];
	assign ry = instr[7:5];
	assign rz = instr[4:2];
	assign shamt = instr[4:2];
	assign pc_next = pc_q + 16'd1;

	always_comb begin
		op = op_nop;
		dst = rx;
		use_a = 1'b0;
		use_b = 1'b0;
		imm = '0;
		case (opc)
			opc_li: begin
				op = op_li;
				imm = {{(word_w-imm_w){1'b0}}, instr[imm_w-1:0]};
			end
			opc_addiu: begin
				op = op_addiu;
				use_a = 1'b1;
				imm = {{(word_w-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
			end
			opc_bnez: begin
				op = op_bnez;
				use_a = 1'b1;
				imm = {{(word_w-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
			end
			opc_sll: begin
				if (instr[1:0] == funct_sll) begin
					op = op_sll;
					use_b = 1'b1;
					imm = (shamt == '0) ? word_t'(8) : word_t'(shamt); // 0 shifts by 8.
				end
			end
			opc_addu: begin
				if (instr[1:0] == funct_addu) begin
					op = op_addu;
					use_a = 1'b1;
					use_b = 1'b1;
					dst = rz;
				end
			end
			opc_move: begin
				if (instr[4:0] == funct_move) begin
					op = op_move;
					use_b = 1'b1;
				end
			end
			opc_nop: op = op_nop;
			default: op = op_nop; // unknown decodes as nop.
		endcase
	end

	assign writes = op_writes(op);
	assign ex_busy = ex_busy_dst[reg_w];
	assign ex_dst = ex_busy_dst[reg_w-1:0];

	assign hazard = (use_a && locked[rx]) || (use_b && locked[ry]) ||
		(writes && (locked[dst] || (ex_busy && ex_dst == dst)));
	assign issue = !hazard && !redirect_en;

	assign rd_addr_a = rx;
	assign rd_addr_b = ry;
	assign lock_en = issue && writes;
	assign lock_addr = dst;

	// release the lock held by the instruction being flushed in execute.
	always_comb begin
		cancel_lock = '0;
		if (redirect_en && ex_busy)
			cancel_lock[ex_dst] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc_q <= reset_pc;
		else if (redirect_en)
			pc_q <= redirect_pc;
		else if (!hazard)
			pc_q <= pc_next;
	end

	assign fetch_pc = pc_q;

	always_comb begin
		dec.valid = issue;
		dec.op = op;
		dec.dst = dst;
		dec.opa = (op == op_bnez) ? pc_next : rd_data_a;   // bnez adds to next pc.
		dec.opb = (op == op_bnez) ? rd_data_a : rd_data_b;
		dec.imm = imm;
		dec.pc = pc_q;
	end

endmodule

// File: verilog/alu_exec.sv
`timescale 1ns/1ns

module alu_exec (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    flush,
	input  pipe_pkg::dec_ex_t       dec,
	output pipe_pkg::ex_wb_t        ex,
	output logic [isa_pkg::reg_w:0] busy_dst
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic valid_q;
	dec_ex_t dec_q;
	word_t result;
	word_t target;
	logic taken;

	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= dec.valid && !flush;
	end

	always_ff @(posedge clk) begin
		dec_q <= dec;
	end

	assign target = dec_q.opa + dec_q.imm;

	always_comb begin
		result = '0;
		taken = 1'b0;
		case (dec_q.op)
			op_li:    result = dec_q.imm;
			op_addiu: result = dec_q.opa + dec_q.imm;
			op_addu:  result = dec_q.opa + dec_q.opb;
			op_sll:   result = dec_q.opb << dec_q.imm[3:0];
			op_move:  result = dec_q.opb;
			op_bnez:  taken = (dec_q.opb != '0);
			default:  result = '0;
		endcase
	end

	// the slot behind a taken branch is dropped here.
	always_comb begin
		ex.valid = valid_q && !flush;
		ex.op = dec_q.op;
		ex.dst = dec_q.dst;
		ex.result = result;
		ex.branch_taken = taken;
		ex.target = target;
	end

	assign busy_dst = {valid_q && op_writes(dec_q.op), dec_q.dst};

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic                         clk,
	input  logic                         rst_n,
	input  isa_pkg::reg_idx_t            rd_addr_a,
	input  isa_pkg::reg_idx_t            rd_addr_b,
	output isa_pkg::word_t               rd_data_a,
	output isa_pkg::word_t               rd_data_b,
	input  pipe_pkg::wb_t                wb,
	input  logic                         lock_en,
	input  isa_pkg::reg_idx_t            lock_addr,
	input  logic [isa_pkg::num_regs-1:0] cancel_lock,
	output logic [isa_pkg::num_regs-1:0] locked
);
	import isa_pkg::*;

	word_t regs [num_regs];
	logic [num_regs-1:0] lock_q;
	logic [num_regs-1:0] lock_set;
	logic [num_regs-1:0] lock_clr;

	always_ff @(posedge clk) begin
		if (wb.en)
			regs[wb.addr] <= wb.data;
	end

	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

	always_comb begin
		lock_set = '0;
		if (lock_en)
			lock_set[lock_addr] = 1'b1;
	end

	// writeback unlocks on the same edge it writes.
	always_comb begin
		lock_clr = cancel_lock;
		if (wb.en)
			lock_clr[wb.addr] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			lock_q <= '0;
		else
			lock_q <= (lock_q & ~lock_clr) | lock_set;
	end

	assign locked = lock_q;

endmodule

// File: verilog/exe_wb.sv
`timescale 1ns/1ns

module exe_wb (
	input  logic             clk,
	input  logic             rst_n,
	input  pipe_pkg::ex_wb_t ex,
	output pipe_pkg::wb_t    wb,
	output logic             redirect_en,
	output isa_pkg::word_t   redirect_pc
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic wr_d;
	logic br_d;
	logic wr_q;
	reg_idx_t addr_q;
	word_t data_q;

	always_comb begin
		wr_d = 1'b0;
		br_d = 1'b0;
		if (ex.valid) begin
			case (ex.op)
				op_li, op_addiu, op_addu, op_sll, op_move: wr_d = 1'b1;
				op_bnez: br_d = ex.branch_taken;   // not taken does nothing.
				default: wr_d = 1'b0;
			endcase
		end
	end

	// one pulse per instruction, low again next cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_q <= 1'b0;
			redirect_en <= 1'b0;
		end else begin
			wr_q <= wr_d;
			redirect_en <= br_d;
		end
	end

	always_ff @(posedge clk) begin
		addr_q <= ex.dst;
		data_q <= ex.result;
		redirect_pc <= ex.target;
	end

	always_comb begin
		wb.en = wr_q;
		wb.addr = addr_q;
		wb.data = data_q;
	end

endmodule

// File: verilog/mini_core.sv
`timescale 1ns/1ns

module mini_core #(
	parameter isa_pkg::word_t reset_pc = 16'h0000
) (
	input  logic           clk,
	input  logic           rst_n,
	input  isa_pkg::word_t instr,
	output isa_pkg::word_t fetch_pc,
	output pipe_pkg::wb_t  wb,
	output logic           redirect_en
);
	import isa_pkg::*;
	import pipe_pkg::*;

	reg_idx_t rd_addr_a;
	reg_idx_t rd_addr_b;
	word_t rd_data_a;
	word_t rd_data_b;
	logic [num_regs-1:0] locked;
	logic [num_regs-1:0] cancel_lock;
	logic lock_en;
	reg_idx_t lock_addr;
	logic [reg_w:0] busy_dst;
	word_t redirect_pc;
	dec_ex_t dec;
	ex_wb_t ex;

	fetch_decode #(
		.reset_pc(reset_pc)
	) u_fetch_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr      (instr),
		.fetch_pc   (fetch_pc),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.locked     (locked),
		.lock_en    (lock_en),
		.lock_addr  (lock_addr),
		.cancel_lock(cancel_lock),
		.ex_busy_dst(busy_dst),
		.redirect_en(redirect_en),
		.redirect_pc(redirect_pc),
		.dec        (dec)
	);

	// a taken branch flushes the execute slot.
	alu_exec u_alu_exec (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush   (redirect_en),
		.dec     (dec),
		.ex      (ex),
		.busy_dst(busy_dst)
	);

	reg_file u_reg_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.wb         (wb),
		.lock_en    (lock_en),
		.lock_addr  (lock_addr),
		.cancel_lock(cancel_lock),
		.locked     (locked)
	);

	exe_wb u_exe_wb (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex         (ex),
		.wb         (wb),
		.redirect_en(redirect_en),
		.redirect_pc(redirect_pc)
	);

endmodule

// File: bench/mini_core_tb.sv
`timescale 1ns/1ns

module mini_core_tb;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam word_t reset_pc = 16'h0020;
	localparam int mem_words = 256;

	bit clk;
	logic rst_n;
	word_t instr;
	word_t fetch_pc;
	wb_t wb;
	logic redirect_en;

	word_t imem [mem_words];
	word_t prog_pc;
	word_t end_pc;
	wb_t exp_wr [$];
	word_t exp_br [$];
	int model_writes;
	int model_branches;
	int limit_cycles;
	int seed;
	int checks;
	int errors;
	int wr_count;
	int br_count;
	logic pc_check_due;
	word_t want_pc;

	mini_core #(.reset_pc(reset_pc)) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr      (instr),
		.fetch_pc   (fetch_pc),
		.wb         (wb),
		.redirect_en(redirect_en)
	);

	always #50 clk = ~clk;

	function automatic word_t li_word(reg_idx_t rx, logic [7:0] imm);
		return {opc_li, rx, imm};
	endfunction

	function automatic word_t addiu_word(reg_idx_t rx, logic [7:0] imm);
		return {opc_addiu, rx, imm};
	endfunction

	function automatic word_t bnez_word(reg_idx_t rx, logic [7:0] off);
		return {opc_bnez, rx, off};
	endfunction

	function automatic word_t sll_word(reg_idx_t rx, reg_idx_t ry, logic [2:0] sa);
		return {opc_sll, rx, ry, sa, funct_sll};
	endfunction

	function automatic word_t addu_word(reg_idx_t rx, reg_idx_t ry, reg_idx_t rz);
		return {opc_addu, rx, ry, rz, funct_addu};
	endfunction

	function automatic word_t move_word(reg_idx_t rx, reg_idx_t ry);
		return {opc_move, rx, ry, funct_move};
	endfunction

	function automatic word_t nop_word(logic [10:0] tag);
		return {opc_nop, tag};
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic emit(input word_t w);
		imem[prog_pc[7:0]] = w;
		prog_pc = prog_pc + 16'd1;
	endtask

	task automatic count_mismatch(input string msg);
		errors++;
		$display("FAILED %0t: %s", $time, msg);
	endtask

	task automatic count_problem(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic build_program();
		word_t loop_pc;
		logic [7:0] b;
		for (int a = 0; a < mem_words; a++)
			imem[a] = nop_word(11'(a));   // idle words carry their address.
		prog_pc = reset_pc;
		for (int r = 0; r < num_regs; r++) begin
			b = rand_byte();
			if (r == 2)
				b[7] = 1'b1;   // li must zero extend this one.
			emit(li_word(reg_idx_t'(r), b));
		end
		emit(nop_word(11'd0));
		for (int r = 0; r < 4; r++) begin
			b = rand_byte();
			b[7] = (r == 1);   // one negative, the rest positive.
			emit(addiu_word(reg_idx_t'(r), b));
		end
		emit(nop_word(11'd0));
		// each step reads the result of the one before.
		emit(addu_word(3'd1, 3'd2, 3'd4));
		emit(sll_word(3'd5, 3'd4, 3'd0));   // shift amount 0 means 8.
		emit(sll_word(3'd6, 3'd5, 3'd3));
		emit(move_word(3'd3, 3'd6));
		emit(addu_word(3'd3, 3'd4, 3'd0));
		emit(nop_word(11'd0));
		emit(nop_word(11'd0));
		emit(li_word(3'd7, 8'd3));   // loop count.
		loop_pc = prog_pc;
		emit(addiu_word(3'd1, rand_byte()));
		emit(addu_word(3'd1, 3'd2, 3'd2));
		emit(addiu_word(3'd7, 8'hff));
		emit(bnez_word(3'd7, 8'(loop_pc - prog_pc - 16'd1)));
		emit(li_word(3'd5, 8'haa));   // flushed on every taken pass.
		emit(li_word(3'd6, 8'h55));
		emit(nop_word(11'd0));
		end_pc = prog_pc;
	endtask

	// program order model of the instruction set.
	task automatic run_model();
		word_t r [num_regs];
		word_t pc;
		word_t w;
		word_t sext;
		word_t wd;
		logic [3:0] amt;
		logic wr;
		reg_idx_t wa;
		wb_t e;
		int steps;
		pc = reset_pc;
		steps = 0;
		while (pc != end_pc && steps < 1000) begin
			w = imem[pc[7:0]];
			sext = {{8{w[7]}}, w[7:0]};
			amt = (w[4:2] == 3'd0) ? 4'd8 : {1'b0, w[4:2]};
			wr = 1'b1;
			wa = w[10:8];
			wd = '0;
			pc = pc + 16'd1;
			case (opcode_e'(w[15:11]))
				opc_li:    wd = {8'h00, w[7:0]};
				opc_addiu: wd = r[w[10:8]] + sext;
				opc_sll:   wd = r[w[7:5]] << amt;
				opc_move:  wd = r[w[7:5]];
				opc_addu: begin
					wa = w[4:2];
					wd = r[w[10:8]] + r[w[7:5]];
				end
				opc_bnez: begin
					wr = 1'b0;
					if (r[w[10:8]] != 16'd0) begin
						pc = pc + sext;
						exp_br.push_back(pc);
					end
				end
				default: wr = 1'b0;
			endcase
			if (wr) begin
				r[wa] = wd;
				e.en = 1'b1;
				e.addr = wa;
				e.data = wd;
				exp_wr.push_back(e);
			end
			steps++;
		end
		model_writes = exp_wr.size();
		model_branches = exp_br.size();
		limit_cycles = steps * 10 + 40;
	endtask

	task automatic check_idle(input string phase);
		checks++;
		assert (!wb.en && !redirect_en && fetch_pc == reset_pc)
		else count_mismatch($sformatf("%s: wb.en %b redirect_en %b fetch_pc %h, expected %h",
			phase, wb.en, redirect_en, fetch_pc, reset_pc));
	endtask

	task automatic check_outputs();
		wb_t want;
		if (pc_check_due) begin
			checks++;
			assert (fetch_pc == want_pc)
			else count_mismatch($sformatf("fetch_pc %h after redirect, expected %h",
				fetch_pc, want_pc));
			pc_check_due = 1'b0;
		end
		if (wb.en) begin
			wr_count++;
			checks++;
			assert (exp_wr.size() != 0)
			else count_problem($sformatf("extra register write to r%0d at time %0t",
				wb.addr, $time));
			if (exp_wr.size() != 0) begin
				want = exp_wr.pop_front();
				checks++;
				assert (wb.addr == want.addr && wb.data == want.data)
				else count_mismatch($sformatf("write r%0d = %h, expected r%0d = %h",
					wb.addr, wb.data, want.addr, want.data));
			end
		end
		if (redirect_en) begin
			br_count++;
			checks++;
			assert (exp_br.size() != 0)
			else count_problem($sformatf("extra redirect at time %0t", $time));
			if (exp_br.size() != 0) begin
				want_pc = exp_br.pop_front();
				pc_check_due = 1'b1;   // target shows on fetch_pc next cycle.
			end
		end
	endtask

	initial begin
		instr = nop_word(11'd0);
		forever begin
			@(posedge clk);
			#1 instr = imem[fetch_pc[7:0]];
		end
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the core did not finish the program within %0d cycles", limit_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		seed = 32591;
		checks = 0;
		errors = 0;
		wr_count = 0;
		br_count = 0;
		pc_check_due = 1'b0;
		want_pc = '0;
		limit_cycles = 0;
		build_program();
		run_model();
		@(posedge clk);   // first reset edge.
		repeat (7) begin
			@(negedge clk);
			check_idle("during reset");
		end
		@(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		check_idle("first cycle after reset");
		while (fetch_pc != end_pc + 16'd4) begin
			@(negedge clk);
			check_outputs();
		end
		repeat (3) begin
			@(negedge clk);
			check_outputs();
		end
		checks++;
		assert (wr_count == model_writes && exp_wr.size() == 0)
		else count_problem($sformatf("saw %0d register writes, the model made %0d",
			wr_count, model_writes));
		checks++;
		assert (br_count == model_branches && exp_br.size() == 0)
		else count_problem($sformatf("saw %0d redirects, the model took %0d branches",
			br_count, model_branches));
		$display("checks %0d, errors %0d, writes %0d of %0d, redirects %0d of %0d",
			checks, errors, wr_count, model_writes, br_count, model_branches);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: mini_core.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_decode.sv
verilog/alu_exec.sv
verilog/reg_file.sv
verilog/exe_wb.sv
verilog/mini_core.sv
bench/mini_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f mini_core.f \
	--top-module mini_core_tb -o mini_core_tb; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/mini_core_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1
